/* common/bgpu_defs.svh */
// Width, calibration and memory latency macros for the BGPU wrapper
`ifndef BGPU_DEFS_SVH
`define BGPU_DEFS_SVH

// Memory word address width, 1024 words
`define BGPU_ADDR_W 10

// Data word width
`define BGPU_DATA_W 32

// Word count width of one command
`define BGPU_CNT_W 8

// Clock cycles from reset release to calibration done
`define BGPU_CALIB_CYCLES 16

// Cycles from an accepted read to its response
`define BGPU_RD_LAT 2

`endif

/* common/bgpu_pkg.sv */
// Opcode and state enums, command, memory and datapath control structs
`include "bgpu_defs.svh"

package bgpu_pkg;

    // Bulk operations
    typedef enum logic [1:0] {
        OP_FILL = 2'd0,
        OP_COPY = 2'd1,
        OP_SUM  = 2'd2
    } opcode_e;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        FILL,
        COPY_RD,
        COPY_WAIT,
        COPY_WR,
        SUM_ISSUE,
        SUM_DRAIN,
        DONE
    } ctrl_state_e;

    // One bulk command
    typedef struct packed {
        opcode_e                  op;
        logic [`BGPU_ADDR_W-1:0]  src_addr;
        logic [`BGPU_ADDR_W-1:0]  dst_addr;
        logic [`BGPU_CNT_W-1:0]   count;
        logic [`BGPU_DATA_W-1:0]  value;
    } bgpu_cmd_t;

    // Memory request, always accepted
    typedef struct packed {
        logic                     valid;
        logic                     write;
        logic [`BGPU_ADDR_W-1:0]  addr;
        logic [`BGPU_DATA_W-1:0]  wdata;
    } mem_req_t;

    // Read response
    typedef struct packed {
        logic                     valid;
        logic [`BGPU_DATA_W-1:0]  rdata;
    } mem_rsp_t;

    // Strobes from the FSM to the lane datapath
    typedef struct packed {
        logic load;
        logic req_valid;
        logic req_write;
        logic use_dst;
        logic src_step;
        logic dst_step;
        logic cnt_step;
        logic acc_clr;
        logic acc_en;
        logic buf_en;
        logic wsel_buf;
    } dp_ctrl_t;

endpackage : bgpu_pkg

/* mctrl/mctrl_calib.sv */
// Calibration sequencer with settle counter and sticky ready flag
`timescale 1ns/100ps
`include "bgpu_defs.svh"

module mctrl_calib (
    input  logic sys_clk_i,
    input  logic rst_n_i,
    output logic calib_done_o
);
    // Counter wide enough for the full settle time
    localparam int unsigned CntW = $clog2(`BGPU_CALIB_CYCLES + 1);

    logic [CntW-1:0] settle_q;
    logic            done_q;

    // Counts down from the settle time, done sets on the last step
    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            settle_q <= CntW'(`BGPU_CALIB_CYCLES);
            done_q   <= 1'b0;
        end else begin
            if (settle_q != '0) begin
                settle_q <= settle_q - 1'b1;
            end
            // Sticky until the next reset
            if (settle_q == CntW'(1)) begin
                done_q <= 1'b1;
            end
        end
    end

    assign calib_done_o = done_q;

endmodule : mctrl_calib

/* mctrl/mctrl_mem.sv */
// Word memory with single-cycle writes and a fixed-latency read pipeline
`timescale 1ns/100ps
`include "bgpu_defs.svh"

module mctrl_mem (
    input  logic                sys_clk_i,
    input  logic                rst_n_i,
    input  bgpu_pkg::mem_req_t  mem_req_i,
    output bgpu_pkg::mem_rsp_t  mem_rsp_o
);
    import bgpu_pkg::*;

    localparam int unsigned Depth = 1 << `BGPU_ADDR_W;
    localparam int unsigned RdLat = `BGPU_RD_LAT;

    // Storage, contents undefined after power-up
    logic [`BGPU_DATA_W-1:0] mem_q [Depth];

    // Read pipeline, valid bits and data
    logic [RdLat-1:0]        rd_vld_q;
    logic [`BGPU_DATA_W-1:0] rd_dat_q [RdLat];

    logic rd_req;

    assign rd_req = mem_req_i.valid & ~mem_req_i.write;

    // Write lands on the request edge
    always_ff @(posedge sys_clk_i) begin
        if (mem_req_i.valid && mem_req_i.write) begin
            mem_q[mem_req_i.addr] <= mem_req_i.wdata;
        end
    end

    // Valid shift register
    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_vld_q <= '0;
        end else begin
            rd_vld_q <= {rd_vld_q[RdLat-2:0], rd_req};
        end
    end

    // Data follows valid stage by stage
    always_ff @(posedge sys_clk_i) begin
        rd_dat_q[0] <= mem_q[mem_req_i.addr];
        for (int i = 1; i < RdLat; i++) begin
            rd_dat_q[i] <= rd_dat_q[i-1];
        end
    end

    // Last stage is the response
    assign mem_rsp_o.valid = rd_vld_q[RdLat-1];
    assign mem_rsp_o.rdata = rd_dat_q[RdLat-1];

endmodule : mctrl_mem

/* soc/bgpu_ctrl.sv */
// Command FSM sequencing FILL, COPY and SUM with outstanding read tracking
`timescale 1ns/100ps
`include "bgpu_defs.svh"

module bgpu_ctrl (
    input  logic                sys_clk_i,
    input  logic                rst_n_i,
    input  logic                cmd_valid_i,
    input  bgpu_pkg::opcode_e   op_i,
    input  logic                last_i,
    input  bgpu_pkg::mem_rsp_t  mem_rsp_i,
    output bgpu_pkg::dp_ctrl_t  dp_ctrl_o,
    output logic                busy_o,
    output logic                done_o
);
    import bgpu_pkg::*;

    // Enough room for every read in flight
    localparam int unsigned OutW = $clog2(`BGPU_RD_LAT + 1);

    ctrl_state_e     state_q, state_d;
    logic [OutW-1:0] rd_out_q;
    logic            rd_issue;

    // ###################################################################
    // Outstanding reads
    // ###################################################################

    assign rd_issue = dp_ctrl_o.req_valid & ~dp_ctrl_o.req_write;

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_out_q <= '0;
        end else begin
            rd_out_q <= rd_out_q + OutW'(rd_issue) - OutW'(mem_rsp_i.valid);
        end
    end

    // ###################################################################
    // Next state and datapath strobes
    // ###################################################################

    // Strobes never depend on last_i, so last_o may look at them
    always_comb begin
        state_d   = state_q;
        dp_ctrl_o = '0;
        case (state_q)
            IDLE: begin
                if (cmd_valid_i) begin
                    dp_ctrl_o.load    = 1'b1;
                    dp_ctrl_o.acc_clr = 1'b1;
                    // Zero count skips memory
                    if (last_i) begin
                        state_d = DONE;
                    end else begin
                        case (op_i)
                            OP_FILL: state_d = FILL;
                            OP_COPY: state_d = COPY_RD;
                            OP_SUM:  state_d = SUM_ISSUE;
                            default: state_d = DONE;
                        endcase
                    end
                end
            end
            FILL: begin
                // One write per cycle
                dp_ctrl_o.req_valid = 1'b1;
                dp_ctrl_o.req_write = 1'b1;
                dp_ctrl_o.use_dst   = 1'b1;
                dp_ctrl_o.dst_step  = 1'b1;
                dp_ctrl_o.cnt_step  = 1'b1;
                if (last_i) begin
                    state_d = DONE;
                end
            end
            COPY_RD: begin
                dp_ctrl_o.req_valid = 1'b1;
                dp_ctrl_o.src_step  = 1'b1;
                state_d             = COPY_WAIT;
            end
            COPY_WAIT: begin
                // Hold until the word comes back
                if (mem_rsp_i.valid) begin
                    dp_ctrl_o.buf_en = 1'b1;
                    state_d          = COPY_WR;
                end
            end
            COPY_WR: begin
                dp_ctrl_o.req_valid = 1'b1;
                dp_ctrl_o.req_write = 1'b1;
                dp_ctrl_o.use_dst   = 1'b1;
                dp_ctrl_o.wsel_buf  = 1'b1;
                dp_ctrl_o.dst_step  = 1'b1;
                dp_ctrl_o.cnt_step  = 1'b1;
                state_d             = last_i ? DONE : COPY_RD;
            end
            SUM_ISSUE: begin
                // Back to back reads, responses add as they come
                dp_ctrl_o.req_valid = 1'b1;
                dp_ctrl_o.src_step  = 1'b1;
                dp_ctrl_o.cnt_step  = 1'b1;
                dp_ctrl_o.acc_en    = mem_rsp_i.valid;
                if (last_i) begin
                    state_d = SUM_DRAIN;
                end
            end
            SUM_DRAIN: begin
                dp_ctrl_o.acc_en = mem_rsp_i.valid;
                // Final response is in this cycle
                if (rd_out_q == OutW'(1) && mem_rsp_i.valid) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Busy through the done cycle
    assign busy_o = (state_q != IDLE);
    assign done_o = (state_q == DONE);

endmodule : bgpu_ctrl

/* soc/lane_datapath.sv */
// Address counters, word count, copy buffer, accumulator and request build
`timescale 1ns/100ps
`include "bgpu_defs.svh"

module lane_datapath (
    input  logic                     sys_clk_i,
    input  logic                     rst_n_i,
    input  bgpu_pkg::bgpu_cmd_t      cmd_i,
    input  bgpu_pkg::dp_ctrl_t       dp_ctrl_i,
    input  bgpu_pkg::mem_rsp_t       mem_rsp_i,
    output bgpu_pkg::mem_req_t       mem_req_o,
    output logic                     last_o,
    output logic [`BGPU_DATA_W-1:0]  result_o
);
    import bgpu_pkg::*;

    // Payload registers
    logic [`BGPU_ADDR_W-1:0] src_q, dst_q;
    logic [`BGPU_DATA_W-1:0] value_q, buf_q;

    // Control registers
    logic [`BGPU_CNT_W-1:0]  cnt_q, cnt_d;
    logic [`BGPU_DATA_W-1:0] acc_q;

    // Remaining count after this cycle's strobes
    always_comb begin
        if (dp_ctrl_i.load) begin
            cnt_d = cmd_i.count;
        end else if (dp_ctrl_i.cnt_step) begin
            cnt_d = cnt_q - 1'b1;
        end else begin
            cnt_d = cnt_q;
        end
    end

    // Lets the FSM end on the final word without an extra cycle
    assign last_o = (cnt_d == '0);

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
            acc_q <= '0;
        end else begin
            cnt_q <= cnt_d;
            if (dp_ctrl_i.acc_clr) begin
                acc_q <= '0;
            end else if (dp_ctrl_i.acc_en) begin
                // Wraps at word width
                acc_q <= acc_q + mem_rsp_i.rdata;
            end
        end
    end

    // Address counters, fill value and copy buffer
    always_ff @(posedge sys_clk_i) begin
        if (dp_ctrl_i.load) begin
            src_q   <= cmd_i.src_addr;
            dst_q   <= cmd_i.dst_addr;
            value_q <= cmd_i.value;
        end else begin
            if (dp_ctrl_i.src_step) begin
                src_q <= src_q + 1'b1;
            end
            if (dp_ctrl_i.dst_step) begin
                dst_q <= dst_q + 1'b1;
            end
        end
        if (dp_ctrl_i.buf_en) begin
            buf_q <= mem_rsp_i.rdata;
        end
    end

    // Request build
    assign mem_req_o.valid = dp_ctrl_i.req_valid;
    assign mem_req_o.write = dp_ctrl_i.req_write;
    assign mem_req_o.addr  = dp_ctrl_i.use_dst ? dst_q : src_q;
    assign mem_req_o.wdata = dp_ctrl_i.wsel_buf ? buf_q : value_q;

    // Zero unless the last command was a SUM
    assign result_o = acc_q;

endmodule : lane_datapath

/* verilog/bgpu_wrapper.sv */
// BGPU top level with calibration-gated reset, status LEDs and all instances
`timescale 1ns/100ps
`include "bgpu_defs.svh"

module bgpu_wrapper (
    // System clock and reset button
    input  logic                     sys_clk_i,
    input  logic                     rst_n_i,

    // Command strobe and payload
    input  logic                     cmd_valid_i,
    input  bgpu_pkg::bgpu_cmd_t      cmd_i,

    // Status and completion
    output logic                     busy_o,
    output logic                     done_o,
    output logic [`BGPU_DATA_W-1:0]  result_o,

    // Active low status LEDs
    output logic [7:0]               led_o
);
    import bgpu_pkg::*;

    // ###################################################################
    // Signals
    // ###################################################################

    // Memory ready
    logic calib_done;

    // Compute side reset, held until calibration is done
    logic soc_rst_n;

    // Controller to datapath
    dp_ctrl_t dp_ctrl;
    logic     last;
    logic     ctrl_busy;

    // Memory port
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    // ###################################################################
    // Reset
    // ###################################################################

    // Compute side stays in reset until memory is calibrated
    assign soc_rst_n = rst_n_i & calib_done;

    // Busy also covers the calibration window
    assign busy_o = ctrl_busy | ~calib_done;

    // ###################################################################
    // Memory controller model
    // ###################################################################

    mctrl_calib i_mctrl_calib (
        .sys_clk_i   ( sys_clk_i  ),
        .rst_n_i     ( rst_n_i    ),
        .calib_done_o( calib_done )
    );

    mctrl_mem i_mctrl_mem (
        .sys_clk_i( sys_clk_i ),
        .rst_n_i  ( rst_n_i   ),
        .mem_req_i( mem_req   ),
        .mem_rsp_o( mem_rsp   )
    );

    // ###################################################################
    // Compute core
    // ###################################################################

    bgpu_ctrl i_bgpu_ctrl (
        .sys_clk_i  ( sys_clk_i   ),
        .rst_n_i    ( soc_rst_n   ),
        .cmd_valid_i( cmd_valid_i ),
        .op_i       ( cmd_i.op    ),
        .last_i     ( last        ),
        .mem_rsp_i  ( mem_rsp     ),
        .dp_ctrl_o  ( dp_ctrl     ),
        .busy_o     ( ctrl_busy   ),
        .done_o     ( done_o      )
    );

    lane_datapath i_lane_datapath (
        .sys_clk_i( sys_clk_i ),
        .rst_n_i  ( soc_rst_n ),
        .cmd_i    ( cmd_i     ),
        .dp_ctrl_i( dp_ctrl   ),
        .mem_rsp_i( mem_rsp   ),
        .mem_req_o( mem_req   ),
        .last_o   ( last      ),
        .result_o ( result_o  )
    );

    // ###################################################################
    // Status LEDs
    // ###################################################################

    // Lit once memory is calibrated
    assign led_o[0] = ~calib_done;
    // Lit while compute side is out of reset
    assign led_o[1] = ~soc_rst_n;
    // Lit while the reset button is pressed
    assign led_o[2] = rst_n_i;
    // Lit while a command runs
    assign led_o[3] = ~ctrl_busy;
    // Unused
    assign led_o[7:4] = '1;

endmodule : bgpu_wrapper

/* test/bgpu_wrapper_sva.sv */
// Bound assertions on done pulse width, reset gating and read latency
`timescale 1ns/100ps
`include "bgpu_defs.svh"

module bgpu_wrapper_sva (
    input logic               sys_clk_i,
    input logic               rst_n_i,
    input logic               calib_done_i,
    input logic               done_i,
    input bgpu_pkg::mem_req_t mem_req_i,
    input bgpu_pkg::mem_rsp_t mem_rsp_i
);
    logic rd_req;

    assign rd_req = mem_req_i.valid & ~mem_req_i.write;

    // Completion is a single cycle pulse
    done_pulse: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        done_i |=> !done_i)
        else $error("done_o stayed high for more than one cycle");

    // Memory idle until calibrated, reset included
    req_gated: assert property (@(posedge sys_clk_i)
        !calib_done_i |-> !mem_req_i.valid)
        else $error("memory request issued before calibration");

    // Every read answered after the fixed latency
    rd_latency: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        rd_req |-> ##(`BGPU_RD_LAT) mem_rsp_i.valid)
        else $error("read response missing at the expected cycle");

    // No response without a matching read
    rsp_source: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        mem_rsp_i.valid |-> $past(rd_req, `BGPU_RD_LAT))
        else $error("read response without a read request");

endmodule : bgpu_wrapper_sva

bind bgpu_wrapper bgpu_wrapper_sva i_bgpu_wrapper_sva (
    .sys_clk_i   ( sys_clk_i  ),
    .rst_n_i     ( rst_n_i    ),
    .calib_done_i( calib_done ),
    .done_i      ( done_o     ),
    .mem_req_i   ( mem_req    ),
    .mem_rsp_i   ( mem_rsp    )
);

/* test/tb_bgpu_wrapper.sv */
// Testbench with clock, reset, LCG, reference memory, command tasks, checker and watchdog
`timescale 1ns/100ps
`include "bgpu_defs.svh"

module tb_bgpu_wrapper;
    import bgpu_pkg::*;

    localparam int ClkPeriod = 100;
    localparam int StimDly   = 10;
    localparam int MemWords  = 1 << `BGPU_ADDR_W;
    // Commands over all tests, with spare
    localparam int NumCmds   = 60;
    // Full COPY is the longest command, four cycles a word
    localparam int WorstCyc  = 4 * 255 + 8;
    localparam int TimeoutNs = (NumCmds * WorstCyc + `BGPU_CALIB_CYCLES + 200) * ClkPeriod;

    // DUT ports
    logic                    sys_clk_i, rst_n_i, cmd_valid_i;
    bgpu_cmd_t               cmd_i;
    logic                    busy_o, done_o;
    logic [`BGPU_DATA_W-1:0] result_o;
    logic [7:0]              led_o;

    // Reference memory and what the next done_o must show
    logic [`BGPU_DATA_W-1:0] ref_mem [MemWords];
    logic [`BGPU_DATA_W-1:0] exp_result, last_result;
    int                      exp_lat, drive_cyc, cyc, done_cnt;
    logic                    pending, calib_ok;

    // Counts and random state
    int          check_cnt, err_cnt, test_num, test_err0;
    string       test_name;
    logic [31:0] lcg_state;

    bgpu_wrapper DUT (
        .sys_clk_i  ( sys_clk_i   ),
        .rst_n_i    ( rst_n_i     ),
        .cmd_valid_i( cmd_valid_i ),
        .cmd_i      ( cmd_i       ),
        .busy_o     ( busy_o      ),
        .done_o     ( done_o      ),
        .result_o   ( result_o    ),
        .led_o      ( led_o       )
    );

    always #(ClkPeriod / 2) sys_clk_i = ~sys_clk_i;

    always @(posedge sys_clk_i) cyc <= cyc + 1;

    // ##################################################################
    // Helpers
    // ##################################################################

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    // Word addresses wrap like the DUT counters
    function automatic logic [`BGPU_ADDR_W-1:0] wrap_addr(input int unsigned a);
        return a[`BGPU_ADDR_W-1:0];
    endfunction

    // Expected SUM total over the reference memory
    function automatic logic [`BGPU_DATA_W-1:0] ref_sum(input int unsigned addr,
                                                         input int unsigned count);
        logic [`BGPU_DATA_W-1:0] total;
        total = '0;
        for (int unsigned i = 0; i < count; i++) begin
            total = total + ref_mem[wrap_addr(addr + i)];
        end
        return total;
    endfunction

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0d ns: %s: got 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
        end
    endtask

    task automatic begin_test(input string name);
        test_num++;
        test_name = name;
        test_err0 = err_cnt;
    endtask

    task automatic end_test();
        if (err_cnt == test_err0) begin
            $display("Test %0d %s: ok", test_num, test_name);
        end else begin
            $display("Test %0d %s: %0d errors", test_num, test_name, err_cnt - test_err0);
        end
    endtask

    // One command, reference updated, waits for done_o
    task automatic run_cmd(input opcode_e op, input int unsigned src, input int unsigned dst,
                           input int unsigned count, input logic [`BGPU_DATA_W-1:0] value);
        int seen;
        // Expectations come before the reference changes
        exp_result = (op == OP_SUM) ? ref_sum(src, count) : '0;
        if (count == 0) begin
            exp_lat = 1;
        end else if (op == OP_FILL) begin
            exp_lat = count + 1;
        end else if (op == OP_COPY) begin
            exp_lat = 4 * count + 1;
        end else begin
            // One read a cycle, last response after the read latency
            exp_lat = count + `BGPU_RD_LAT + 1;
        end
        // Word by word, so overlapping copies behave as the DUT does
        for (int unsigned i = 0; i < count; i++) begin
            if (op == OP_FILL) begin
                ref_mem[wrap_addr(dst + i)] = value;
            end else if (op == OP_COPY) begin
                ref_mem[wrap_addr(dst + i)] = ref_mem[wrap_addr(src + i)];
            end
        end
        while (busy_o) @(negedge sys_clk_i);
        @(posedge sys_clk_i);
        #StimDly;
        cmd_i.op       = op;
        cmd_i.src_addr = src[`BGPU_ADDR_W-1:0];
        cmd_i.dst_addr = dst[`BGPU_ADDR_W-1:0];
        cmd_i.count    = count[`BGPU_CNT_W-1:0];
        cmd_i.value    = value;
        cmd_valid_i    = 1'b1;
        drive_cyc      = cyc;
        pending        = 1'b1;
        seen           = done_cnt;
        @(posedge sys_clk_i);
        #StimDly;
        cmd_valid_i = 1'b0;
        while (done_cnt == seen) @(posedge sys_clk_i);
        pending = 1'b0;
        // Result holds into the idle cycle
        @(negedge sys_clk_i);
        check_val("result_o holds after done_o", result_o, exp_result);
    endtask

    // ##################################################################
    // Compare process, outputs sampled mid-cycle
    // ##################################################################

    always @(negedge sys_clk_i) begin
        if (calib_ok) begin
            check_val("led_o[3] against busy_o", {31'd0, led_o[3]}, {31'd0, ~busy_o});
        end
        if (done_o) begin
            if (!pending) begin
                err_cnt++;
                $display("done_o came at %0d ns with no command outstanding", $time);
            end else begin
                check_val("result_o on done_o", result_o, exp_result);
                check_val("cycles from acceptance to done_o", cyc - drive_cyc, exp_lat);
            end
            last_result = result_o;
            done_cnt++;
        end
    end

    // Watchdog
    initial begin
        #(TimeoutNs);
        $display("Timeout: the tests did not finish within %0d ns", TimeoutNs);
        $display("TEST FAIL");
        $finish;
    end

    // ##################################################################
    // Tests
    // ##################################################################

    initial begin
        int unsigned             base, cnt, src, dst, sel;
        int                      calib_cyc;
        logic [`BGPU_DATA_W-1:0] val, va, vb, total;
        opcode_e                 op;
        sys_clk_i   = 1'b0;
        rst_n_i     = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        cyc         = 0;
        done_cnt    = 0;
        pending     = 1'b0;
        calib_ok    = 1'b0;
        check_cnt   = 0;
        err_cnt     = 0;
        test_num    = 0;
        lcg_state   = 32'd778;

        // Calibration gating, strobe during calibration ignored
        begin_test("calibration gating");
        repeat (3) @(posedge sys_clk_i);
        @(negedge sys_clk_i);
        check_val("LEDs in reset", {24'd0, led_o}, 32'h0000_00fb);
        check_val("busy_o in reset", {31'd0, busy_o}, 32'd1);
        @(posedge sys_clk_i);
        #StimDly;
        rst_n_i = 1'b1;
        cmd_i   = '{op: OP_FILL, src_addr: '0, dst_addr: '0, count: 8'd5, value: 32'h5a5a_0001};
        calib_cyc = 0;
        @(negedge sys_clk_i);
        while (busy_o) begin
            check_val("LEDs during calibration", {24'd0, led_o}, 32'h0000_00ff);
            calib_cyc++;
            @(posedge sys_clk_i);
            #StimDly;
            cmd_valid_i = (calib_cyc == 4);
            @(negedge sys_clk_i);
        end
        check_val("calibration cycles", calib_cyc, `BGPU_CALIB_CYCLES);
        check_val("LEDs when calibrated", {24'd0, led_o}, 32'h0000_00fc);
        calib_ok = 1'b1;
        end_test();

        // Whole memory filled in runs, then random runs
        begin_test("FILL then SUM");
        for (int unsigned b = 0; b < 9; b++) begin
            base = (b < 5) ? b * 255 : lcg_next() % MemWords;
            cnt  = (b < 4) ? 255 : ((b == 4) ? MemWords - 1020 : 1 + (lcg_next() % 255));
            val  = lcg_next();
            run_cmd(OP_FILL, 0, base, cnt, val);
            run_cmd(OP_SUM, base, 0, cnt, 0);
            check_val("SUM equals count times value", last_result, cnt * val);
        end
        end_test();

        // Copy to a distant region, ends checked word by word
        begin_test("COPY");
        src = 40;
        dst = 700;
        cnt = 64;
        va  = lcg_next();
        vb  = lcg_next();
        run_cmd(OP_FILL, 0, src, 32, va);
        run_cmd(OP_FILL, 0, src + 32, 32, vb);
        total = ref_sum(src, cnt);
        run_cmd(OP_COPY, src, dst, cnt, 0);
        run_cmd(OP_SUM, dst, 0, cnt, 0);
        check_val("COPY destination sum", last_result, total);
        run_cmd(OP_SUM, dst, 0, 1, 0);
        check_val("first copied word", last_result, va);
        run_cmd(OP_SUM, dst + cnt - 1, 0, 1, 0);
        check_val("last copied word", last_result, vb);
        end_test();

        // Mixed stream over one overlapping window
        begin_test("random mixed stream");
        for (int n = 0; n < 30; n++) begin
            sel = lcg_next() % 3;
            op  = (sel == 0) ? OP_FILL : ((sel == 1) ? OP_COPY : OP_SUM);
            src = 256 + (lcg_next() % 128);
            dst = 256 + (lcg_next() % 128);
            cnt = lcg_next() % 48;
            run_cmd(op, src, dst, cnt, lcg_next());
        end
        end_test();

        // Zero count of each opcode leaves memory alone
        begin_test("count zero and status");
        total = ref_sum(300, 8);
        run_cmd(OP_FILL, 0, 300, 0, lcg_next());
        run_cmd(OP_COPY, 40, 300, 0, 0);
        run_cmd(OP_SUM, 300, 0, 0, 0);
        run_cmd(OP_SUM, 300, 0, 8, 0);
        check_val("memory unchanged by zero count", last_result, total);
        end_test();

        $display("Summary: %0d tests, %0d checks, %0d errors", test_num, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : tb_bgpu_wrapper

/* verilog.f */
+incdir+common
common/bgpu_pkg.sv
mctrl/mctrl_calib.sv
mctrl/mctrl_mem.sv
soc/bgpu_ctrl.sv
soc/lane_datapath.sv
verilog/bgpu_wrapper.sv
test/bgpu_wrapper_sva.sv
test/tb_bgpu_wrapper.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the BGPU wrapper testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_bgpu_wrapper \
    -Mdir obj_dir

./obj_dir/Vtb_bgpu_wrapper | tee sim.log

if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then
    exit 1
fi
exit 0
